/* Makefile */
# verilator build and run of the issue stage testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f \
		--top-module tb_issue_stage -Mdir obj_dir
	./obj_dir/Vtb_issue_stage > sim.log
	cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* verilog.f */
+incdir+include
rtl/issue_pkg.sv
rtl/issue_lane.sv
rtl/issue_stage.sv
tests/tb_issue_stage.sv

/* include/tb_issue_table.svh */
/*
 * issue stage stimulus rows with expected valid, address,
 * commit id and already-issued values
 */

`ifndef TB_ISSUE_TABLE_SVH
`define TB_ISSUE_TABLE_SVH

    // first line  issue flush stall jump addr0 cid0 addr1 cid1
    // second line valid addr0 cid0 addr1 cid1 one cycle later, then already_issued now
    // bit k of a two-bit column is lane k
    localparam int NUM_ROWS = 18;

    localparam row_t ROWS [NUM_ROWS] = '{
        // two new instructions, then a jump reports the registered ids
        '{2'b11, 1'b0, 1'b0, 1'b0, 32'h0000_1000, 4'h1, 32'h0000_2004, 4'h2,
          2'b11, 32'h0000_1000, 4'h1, 32'h0000_2004, 4'h2, 2'b00},
        '{2'b11, 1'b0, 1'b0, 1'b1, 32'h0000_1008, 4'h3, 32'h0000_200c, 4'h4,
          2'b11, 32'h0000_1008, 4'h3, 32'h0000_200c, 4'h4, 2'b00},
        // lane 1 not issued shows zeros
        '{2'b01, 1'b0, 1'b0, 1'b0, 32'h0000_1010, 4'h5, 32'h0000_2010, 4'h6,
          2'b01, 32'h0000_1010, 4'h5, 32'h0000_0000, 4'h0, 2'b00},
        // lane 0 repeats, lane 1 repeat was never issued
        '{2'b11, 1'b0, 1'b0, 1'b0, 32'h0000_1010, 4'h5, 32'h0000_2010, 4'h6,
          2'b10, 32'h0000_0000, 4'h0, 32'h0000_2010, 4'h6, 2'b01},
        '{2'b11, 1'b0, 1'b0, 1'b1, 32'h0000_1010, 4'h5, 32'h0000_2018, 4'h7,
          2'b10, 32'h0000_0000, 4'h0, 32'h0000_2018, 4'h7, 2'b01},
        '{2'b11, 1'b0, 1'b0, 1'b0, 32'h0000_1020, 4'h8, 32'h0000_2020, 4'h9,
          2'b11, 32'h0000_1020, 4'h8, 32'h0000_2020, 4'h9, 2'b00},
        // flush kills both lanes and clears history
        '{2'b11, 1'b1, 1'b0, 1'b0, 32'h0000_1020, 4'h8, 32'h0000_2020, 4'h9,
          2'b00, 32'h0000_0000, 4'h0, 32'h0000_0000, 4'h0, 2'b11},
        '{2'b11, 1'b0, 1'b0, 1'b0, 32'h0000_1020, 4'h8, 32'h0000_2020, 4'h9,
          2'b11, 32'h0000_1020, 4'h8, 32'h0000_2020, 4'h9, 2'b00},
        // stall holds outputs and history
        '{2'b11, 1'b0, 1'b1, 1'b0, 32'h0000_1030, 4'ha, 32'h0000_2030, 4'hb,
          2'b11, 32'h0000_1020, 4'h8, 32'h0000_2020, 4'h9, 2'b00},
        '{2'b00, 1'b0, 1'b1, 1'b1, 32'h0000_1020, 4'he, 32'h0000_0000, 4'hf,
          2'b11, 32'h0000_1020, 4'h8, 32'h0000_2020, 4'h9, 2'b01},
        '{2'b11, 1'b0, 1'b0, 1'b0, 32'h0000_1030, 4'ha, 32'h0000_2030, 4'hb,
          2'b11, 32'h0000_1030, 4'ha, 32'h0000_2030, 4'hb, 2'b00},
        // flush during stall clears history only
        '{2'b11, 1'b1, 1'b1, 1'b0, 32'h0000_1030, 4'ha, 32'h0000_2030, 4'hb,
          2'b11, 32'h0000_1030, 4'ha, 32'h0000_2030, 4'hb, 2'b11},
        '{2'b11, 1'b0, 1'b0, 1'b0, 32'h0000_1030, 4'ha, 32'h0000_2030, 4'hb,
          2'b11, 32'h0000_1030, 4'ha, 32'h0000_2030, 4'hb, 2'b00},
        // address zero never counts as a repeat
        '{2'b10, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 4'h1, 32'h0000_0000, 4'h2,
          2'b10, 32'h0000_0000, 4'h0, 32'h0000_0000, 4'h2, 2'b00},
        '{2'b11, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 4'h3, 32'h0000_0000, 4'h4,
          2'b11, 32'h0000_0000, 4'h3, 32'h0000_0000, 4'h4, 2'b00},
        '{2'b00, 1'b0, 1'b0, 1'b1, 32'h0000_1040, 4'h5, 32'h0000_2040, 4'h6,
          2'b00, 32'h0000_0000, 4'h0, 32'h0000_0000, 4'h0, 2'b00},
        '{2'b11, 1'b0, 1'b0, 1'b1, 32'h0000_1040, 4'h5, 32'h0000_2040, 4'h6,
          2'b11, 32'h0000_1040, 4'h5, 32'h0000_2040, 4'h6, 2'b00},
        // no jump, so the report stays zero
        '{2'b00, 1'b0, 1'b0, 1'b0, 32'h0000_0000, 4'h0, 32'h0000_0000, 4'h0,
          2'b00, 32'h0000_0000, 4'h0, 32'h0000_0000, 4'h0, 2'b00}
    };

`endif

/* tests/tb_issue_stage.sv */
/*
 * issue_stage testbench with clock and reset, lfsr payload,
 * typed compare tasks and the table-driven check loop
 */

`timescale 1ns/10ps

`include "issue_defs.svh"

module tb_issue_stage;

    localparam int RST_CYCLES  = 8;
    localparam int RST_TIMEOUT = 32;

    // one table row with stimulus first and results after
    typedef struct packed {
        logic [1:0]            issue;
        logic                  flush;
        logic                  stall;
        logic                  jump;
        issue_pkg::inst_addr_t addr0;
        issue_pkg::commit_id_t cid0;
        issue_pkg::inst_addr_t addr1;
        issue_pkg::commit_id_t cid1;
        logic [1:0]            exp_valid;
        issue_pkg::inst_addr_t exp_addr0;
        issue_pkg::commit_id_t exp_cid0;
        issue_pkg::inst_addr_t exp_addr1;
        issue_pkg::commit_id_t exp_cid1;
        logic [1:0]            exp_issued;
    } row_t;

    `include "tb_issue_table.svh"

    logic                    clk = 1'b0;
    logic                    rst_n = 1'b0;
    logic                    flush_i = 1'b0;
    logic                    stall_i = 1'b0;
    logic                    jump_i = 1'b0;
    logic [`ISSUE_LANES-1:0] issue_i = '0;

    issue_pkg::inst_addr_t addr_i        [`ISSUE_LANES] = '{default: '0};
    issue_pkg::inst_word_t inst_i        [`ISSUE_LANES] = '{default: '0};
    logic                  reg_we_i      [`ISSUE_LANES] = '{default: '0};
    issue_pkg::reg_addr_t  reg_waddr_i   [`ISSUE_LANES] = '{default: '0};
    issue_pkg::reg_addr_t  reg1_raddr_i  [`ISSUE_LANES] = '{default: '0};
    issue_pkg::reg_addr_t  reg2_raddr_i  [`ISSUE_LANES] = '{default: '0};
    logic                  csr_we_i      [`ISSUE_LANES] = '{default: '0};
    issue_pkg::csr_addr_t  csr_waddr_i   [`ISSUE_LANES] = '{default: '0};
    issue_pkg::csr_addr_t  csr_raddr_i   [`ISSUE_LANES] = '{default: '0};
    issue_pkg::imm_t       imm_i         [`ISSUE_LANES] = '{default: '0};
    issue_pkg::dec_info_t  dec_info_i    [`ISSUE_LANES] = '{default: '0};
    logic                  pred_branch_i [`ISSUE_LANES] = '{default: '0};
    logic                  illegal_i     [`ISSUE_LANES] = '{default: '0};
    issue_pkg::commit_id_t commit_id_i   [`ISSUE_LANES] = '{default: '0};

    issue_pkg::inst_addr_t addr_o [`ISSUE_LANES];
    issue_pkg::inst_word_t inst_o [`ISSUE_LANES];
    logic reg_we_o [`ISSUE_LANES];
    issue_pkg::reg_addr_t reg_waddr_o [`ISSUE_LANES];
    issue_pkg::reg_addr_t reg1_raddr_o [`ISSUE_LANES];
    issue_pkg::reg_addr_t reg2_raddr_o [`ISSUE_LANES];
    logic csr_we_o [`ISSUE_LANES];
    issue_pkg::csr_addr_t csr_waddr_o [`ISSUE_LANES];
    issue_pkg::csr_addr_t csr_raddr_o [`ISSUE_LANES];
    issue_pkg::imm_t imm_o [`ISSUE_LANES];
    issue_pkg::dec_info_t dec_info_o [`ISSUE_LANES];
    logic pred_branch_o [`ISSUE_LANES];
    logic illegal_o [`ISSUE_LANES];
    issue_pkg::commit_id_t commit_id_o [`ISSUE_LANES];
    logic valid_o [`ISSUE_LANES];
    logic already_issued_o [`ISSUE_LANES];
    logic [`ISSUE_LANES-1:0] jump_valid_o;
    issue_pkg::commit_id_t jump_commit_id_o [`ISSUE_LANES];

    // expected registered outputs start at zero
    logic                  exp_valid       [`ISSUE_LANES] = '{default: '0};
    issue_pkg::inst_addr_t exp_addr        [`ISSUE_LANES] = '{default: '0};
    issue_pkg::commit_id_t exp_cid         [`ISSUE_LANES] = '{default: '0};
    issue_pkg::inst_word_t exp_inst        [`ISSUE_LANES] = '{default: '0};
    logic                  exp_reg_we      [`ISSUE_LANES] = '{default: '0};
    issue_pkg::reg_addr_t  exp_reg_waddr   [`ISSUE_LANES] = '{default: '0};
    issue_pkg::reg_addr_t  exp_reg1_raddr  [`ISSUE_LANES] = '{default: '0};
    issue_pkg::reg_addr_t  exp_reg2_raddr  [`ISSUE_LANES] = '{default: '0};
    logic                  exp_csr_we      [`ISSUE_LANES] = '{default: '0};
    issue_pkg::csr_addr_t  exp_csr_waddr   [`ISSUE_LANES] = '{default: '0};
    issue_pkg::csr_addr_t  exp_csr_raddr   [`ISSUE_LANES] = '{default: '0};
    issue_pkg::imm_t       exp_imm         [`ISSUE_LANES] = '{default: '0};
    issue_pkg::dec_info_t  exp_dec_info    [`ISSUE_LANES] = '{default: '0};
    logic                  exp_pred_branch [`ISSUE_LANES] = '{default: '0};
    logic                  exp_illegal     [`ISSUE_LANES] = '{default: '0};

    logic [31:0] lfsr_state = 32'h0d13_225d;
    int          checks = 0;
    int          errors = 0;

    issue_stage u_issue_stage (.*);

    always #2 clk = ~clk;

    // maximal length galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [47:0] rand_bits(input int n);
        logic [47:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[46:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input issue_pkg::inst_addr_t exp,
                              input issue_pkg::inst_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_commit_id(input string name, input issue_pkg::commit_id_t exp,
                                   input issue_pkg::commit_id_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input issue_pkg::inst_word_t exp,
                              input issue_pkg::inst_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_csr_addr(input string name, input issue_pkg::csr_addr_t exp,
                                  input issue_pkg::csr_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_imm(input string name, input issue_pkg::imm_t exp,
                             input issue_pkg::imm_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg_addr(input string name, input issue_pkg::reg_addr_t exp,
                                  input issue_pkg::reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_dec_info(input string name, input issue_pkg::dec_info_t exp,
                                  input issue_pkg::dec_info_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < RST_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        released = rst_n;
    endtask

    task automatic drive_payload(input int k);
        inst_i[k]        <= issue_pkg::inst_word_t'(rand_bits(32));
        reg_we_i[k]      <= 1'(rand_bits(1));
        reg_waddr_i[k]   <= issue_pkg::reg_addr_t'(rand_bits(5));
        reg1_raddr_i[k]  <= issue_pkg::reg_addr_t'(rand_bits(5));
        reg2_raddr_i[k]  <= issue_pkg::reg_addr_t'(rand_bits(5));
        csr_we_i[k]      <= 1'(rand_bits(1));
        csr_waddr_i[k]   <= issue_pkg::csr_addr_t'(rand_bits(32));
        csr_raddr_i[k]   <= issue_pkg::csr_addr_t'(rand_bits(32));
        imm_i[k]         <= issue_pkg::imm_t'(rand_bits(32));
        dec_info_i[k]    <= issue_pkg::dec_info_t'(rand_bits(48));
        pred_branch_i[k] <= 1'(rand_bits(1));
        illegal_i[k]     <= 1'(rand_bits(1));
    endtask

    task automatic drive_row(input row_t r);
        issue_i        <= r.issue;
        flush_i        <= r.flush;
        stall_i        <= r.stall;
        jump_i         <= r.jump;
        addr_i[0]      <= r.addr0;
        commit_id_i[0] <= r.cid0;
        addr_i[1]      <= r.addr1;
        commit_id_i[1] <= r.cid1;
        for (int k = 0; k < `ISSUE_LANES; k++) begin
            drive_payload(k);
        end
    endtask

    task automatic check_outputs();
        for (int k = 0; k < `ISSUE_LANES; k++) begin
            check_bit($sformatf("valid_o[%0d]", k), exp_valid[k], valid_o[k]);
            check_addr($sformatf("addr_o[%0d]", k), exp_addr[k], addr_o[k]);
            check_commit_id($sformatf("commit_id_o[%0d]", k), exp_cid[k], commit_id_o[k]);
            check_word($sformatf("inst_o[%0d]", k), exp_inst[k], inst_o[k]);
            check_bit($sformatf("reg_we_o[%0d]", k), exp_reg_we[k], reg_we_o[k]);
            check_reg_addr($sformatf("reg_waddr_o[%0d]", k), exp_reg_waddr[k], reg_waddr_o[k]);
            check_reg_addr($sformatf("reg1_raddr_o[%0d]", k), exp_reg1_raddr[k],
                           reg1_raddr_o[k]);
            check_reg_addr($sformatf("reg2_raddr_o[%0d]", k), exp_reg2_raddr[k],
                           reg2_raddr_o[k]);
            check_bit($sformatf("csr_we_o[%0d]", k), exp_csr_we[k], csr_we_o[k]);
            check_csr_addr($sformatf("csr_waddr_o[%0d]", k), exp_csr_waddr[k],
                           csr_waddr_o[k]);
            check_csr_addr($sformatf("csr_raddr_o[%0d]", k), exp_csr_raddr[k],
                           csr_raddr_o[k]);
            check_imm($sformatf("imm_o[%0d]", k), exp_imm[k], imm_o[k]);
            check_dec_info($sformatf("dec_info_o[%0d]", k), exp_dec_info[k], dec_info_o[k]);
            check_bit($sformatf("pred_branch_o[%0d]", k), exp_pred_branch[k],
                      pred_branch_o[k]);
            check_bit($sformatf("illegal_o[%0d]", k), exp_illegal[k], illegal_o[k]);
        end
    endtask

    // already-issued flag and jump report follow the inputs of this cycle
    task automatic check_comb(input row_t r);
        issue_pkg::commit_id_t cid;
        for (int k = 0; k < `ISSUE_LANES; k++) begin
            cid = r.jump ? exp_cid[k] : '0;
            check_bit($sformatf("already_issued_o[%0d]", k), r.exp_issued[k],
                      already_issued_o[k]);
            check_bit($sformatf("jump_valid_o[%0d]", k), r.jump, jump_valid_o[k]);
            check_commit_id($sformatf("jump_commit_id_o[%0d]", k), cid, jump_commit_id_o[k]);
        end
    endtask

    // payload passes when the lane is valid, zero when squashed, held on stall
    task automatic update_expected(input row_t r);
        if (!r.stall) begin
            for (int k = 0; k < `ISSUE_LANES; k++) begin
                exp_inst[k]        = r.exp_valid[k] ? inst_i[k] : '0;
                exp_reg_we[k]      = r.exp_valid[k] ? reg_we_i[k] : 1'b0;
                exp_reg_waddr[k]   = r.exp_valid[k] ? reg_waddr_i[k] : '0;
                exp_reg1_raddr[k]  = r.exp_valid[k] ? reg1_raddr_i[k] : '0;
                exp_reg2_raddr[k]  = r.exp_valid[k] ? reg2_raddr_i[k] : '0;
                exp_csr_we[k]      = r.exp_valid[k] ? csr_we_i[k] : 1'b0;
                exp_csr_waddr[k]   = r.exp_valid[k] ? csr_waddr_i[k] : '0;
                exp_csr_raddr[k]   = r.exp_valid[k] ? csr_raddr_i[k] : '0;
                exp_imm[k]         = r.exp_valid[k] ? imm_i[k] : '0;
                exp_dec_info[k]    = r.exp_valid[k] ? dec_info_i[k] : '0;
                exp_pred_branch[k] = r.exp_valid[k] ? pred_branch_i[k] : 1'b0;
                exp_illegal[k]     = r.exp_valid[k] ? illegal_i[k] : 1'b0;
            end
        end
        exp_valid[0] = r.exp_valid[0];
        exp_valid[1] = r.exp_valid[1];
        exp_addr[0]  = r.exp_addr0;
        exp_addr[1]  = r.exp_addr1;
        exp_cid[0]   = r.exp_cid0;
        exp_cid[1]   = r.exp_cid1;
    endtask

    initial begin
        logic released;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        wait_reset_release(released);
        if (!released) begin
            $display("reset was not released within %0d cycles", RST_TIMEOUT);
            $display("STATUS: FAIL");
            $finish;
        end else begin
            // everything low and zero out of reset
            @(negedge clk);
            check_outputs();
            check_comb('0);
            for (int r = 0; r < NUM_ROWS; r++) begin
                @(posedge clk);
                drive_row(ROWS[r]);
                @(negedge clk);
                check_outputs();
                check_comb(ROWS[r]);
                update_expected(ROWS[r]);
            end
            // registered result of the last row
            @(posedge clk);
            @(negedge clk);
            check_outputs();
            $display("checks run %0d, errors %0d", checks, errors);
            if (errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

/* rtl/issue_stage.sv */
/*
 * dual-issue register stage: one issue_lane per slot and
 * the commit-id report for a taken jump
 */

`timescale 1ns/10ps

`include "issue_defs.svh"

module issue_stage (
    input  logic                          clk,
    input  logic                          rst_n,

    // pipeline controller and hazard unit
    input  logic                          flush_i,
    input  logic                          stall_i,
    input  logic                          jump_i,
    input  logic [`ISSUE_LANES-1:0]       issue_i,

    // decoded fields, entry k belongs to lane k
    input  issue_pkg::inst_addr_t         addr_i        [`ISSUE_LANES],
    input  issue_pkg::inst_word_t         inst_i        [`ISSUE_LANES],
    input  logic                          reg_we_i      [`ISSUE_LANES],
    input  issue_pkg::reg_addr_t          reg_waddr_i   [`ISSUE_LANES],
    input  issue_pkg::reg_addr_t          reg1_raddr_i  [`ISSUE_LANES],
    input  issue_pkg::reg_addr_t          reg2_raddr_i  [`ISSUE_LANES],
    input  logic                          csr_we_i      [`ISSUE_LANES],
    input  issue_pkg::csr_addr_t          csr_waddr_i   [`ISSUE_LANES],
    input  issue_pkg::csr_addr_t          csr_raddr_i   [`ISSUE_LANES],
    input  issue_pkg::imm_t               imm_i         [`ISSUE_LANES],
    input  issue_pkg::dec_info_t          dec_info_i    [`ISSUE_LANES],
    input  logic                          pred_branch_i [`ISSUE_LANES],
    input  logic                          illegal_i     [`ISSUE_LANES],
    input  issue_pkg::commit_id_t         commit_id_i   [`ISSUE_LANES],

    // registered fields towards execute
    output issue_pkg::inst_addr_t         addr_o        [`ISSUE_LANES],
    output issue_pkg::inst_word_t         inst_o        [`ISSUE_LANES],
    output logic                          reg_we_o      [`ISSUE_LANES],
    output issue_pkg::reg_addr_t          reg_waddr_o   [`ISSUE_LANES],
    output issue_pkg::reg_addr_t          reg1_raddr_o  [`ISSUE_LANES],
    output issue_pkg::reg_addr_t          reg2_raddr_o  [`ISSUE_LANES],
    output logic                          csr_we_o      [`ISSUE_LANES],
    output issue_pkg::csr_addr_t          csr_waddr_o   [`ISSUE_LANES],
    output issue_pkg::csr_addr_t          csr_raddr_o   [`ISSUE_LANES],
    output issue_pkg::imm_t               imm_o         [`ISSUE_LANES],
    output issue_pkg::dec_info_t          dec_info_o    [`ISSUE_LANES],
    output logic                          pred_branch_o [`ISSUE_LANES],
    output logic                          illegal_o     [`ISSUE_LANES],
    output issue_pkg::commit_id_t         commit_id_o   [`ISSUE_LANES],
    output logic                          valid_o       [`ISSUE_LANES],
    output logic                          already_issued_o [`ISSUE_LANES],

    // commit fifo retire request on a taken jump
    output logic [`ISSUE_LANES-1:0]       jump_valid_o,
    output issue_pkg::commit_id_t         jump_commit_id_o [`ISSUE_LANES]
);

    // every lane reports on a jump
    assign jump_valid_o = {`ISSUE_LANES{jump_i}};

    for (genvar k = 0; k < `ISSUE_LANES; k++) begin : g_lane

        issue_lane u_lane (
            .clk              (clk),
            .rst_n            (rst_n),
            .flush_i          (flush_i),
            .stall_i          (stall_i),
            .issue_i          (issue_i[k]),
            .addr_i           (addr_i[k]),
            .inst_i           (inst_i[k]),
            .reg_we_i         (reg_we_i[k]),
            .reg_waddr_i      (reg_waddr_i[k]),
            .reg1_raddr_i     (reg1_raddr_i[k]),
            .reg2_raddr_i     (reg2_raddr_i[k]),
            .csr_we_i         (csr_we_i[k]),
            .csr_waddr_i      (csr_waddr_i[k]),
            .csr_raddr_i      (csr_raddr_i[k]),
            .imm_i            (imm_i[k]),
            .dec_info_i       (dec_info_i[k]),
            .pred_branch_i    (pred_branch_i[k]),
            .illegal_i        (illegal_i[k]),
            .commit_id_i      (commit_id_i[k]),
            .addr_o           (addr_o[k]),
            .inst_o           (inst_o[k]),
            .reg_we_o         (reg_we_o[k]),
            .reg_waddr_o      (reg_waddr_o[k]),
            .reg1_raddr_o     (reg1_raddr_o[k]),
            .reg2_raddr_o     (reg2_raddr_o[k]),
            .csr_we_o         (csr_we_o[k]),
            .csr_waddr_o      (csr_waddr_o[k]),
            .csr_raddr_o      (csr_raddr_o[k]),
            .imm_o            (imm_o[k]),
            .dec_info_o       (dec_info_o[k]),
            .pred_branch_o    (pred_branch_o[k]),
            .illegal_o        (illegal_o[k]),
            .commit_id_o      (commit_id_o[k]),
            .valid_o          (valid_o[k]),
            .already_issued_o (already_issued_o[k])
        );

        // registered tag of the instruction now in execute
        // zero when no jump so the fifo sees nothing
        assign jump_commit_id_o[k] = jump_i ? commit_id_o[k] : '0;

    end

endmodule

/* rtl/issue_lane.sv */
/*
 * single issue lane: duplicate-issue history, squash logic,
 * registered decode fields and lane assertions
 */

`timescale 1ns/10ps

module issue_lane (
    input  logic                   clk,
    input  logic                   rst_n,

    // pipeline control
    input  logic                   flush_i,
    input  logic                   stall_i,
    input  logic                   issue_i,

    // decoded fields from decode
    input  issue_pkg::inst_addr_t  addr_i,
    input  issue_pkg::inst_word_t  inst_i,
    input  logic                   reg_we_i,
    input  issue_pkg::reg_addr_t   reg_waddr_i,
    input  issue_pkg::reg_addr_t   reg1_raddr_i,
    input  issue_pkg::reg_addr_t   reg2_raddr_i,
    input  logic                   csr_we_i,
    input  issue_pkg::csr_addr_t   csr_waddr_i,
    input  issue_pkg::csr_addr_t   csr_raddr_i,
    input  issue_pkg::imm_t        imm_i,
    input  issue_pkg::dec_info_t   dec_info_i,
    input  logic                   pred_branch_i,
    input  logic                   illegal_i,
    input  issue_pkg::commit_id_t  commit_id_i,

    // registered fields towards execute
    output issue_pkg::inst_addr_t  addr_o,
    output issue_pkg::inst_word_t  inst_o,
    output logic                   reg_we_o,
    output issue_pkg::reg_addr_t   reg_waddr_o,
    output issue_pkg::reg_addr_t   reg1_raddr_o,
    output issue_pkg::reg_addr_t   reg2_raddr_o,
    output logic                   csr_we_o,
    output issue_pkg::csr_addr_t   csr_waddr_o,
    output issue_pkg::csr_addr_t   csr_raddr_o,
    output issue_pkg::imm_t        imm_o,
    output issue_pkg::dec_info_t   dec_info_o,
    output logic                   pred_branch_o,
    output logic                   illegal_o,
    output issue_pkg::commit_id_t  commit_id_o,
    output logic                   valid_o,

    // same instruction seen again after it was issued
    output logic                   already_issued_o
);

    // history of the previous cycle
    issue_pkg::inst_addr_t prev_addr;
    logic                  prev_issued;

    logic same_as_prev;
    logic squash;

    // address zero never counts as a repeat
    assign same_as_prev = (addr_i != '0) && (addr_i == prev_addr);

    assign already_issued_o = same_as_prev && prev_issued;

    // drop the lane on flush, no issue, or a repeat of an issued instruction
    assign squash = flush_i || !issue_i || already_issued_o;

    // flush wins over stall for the history
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_addr   <= '0;
            prev_issued <= 1'b0;
        end else if (flush_i) begin
            prev_addr   <= '0;
            prev_issued <= 1'b0;
        end else if (!stall_i) begin
            prev_addr   <= addr_i;
            // raw request, kept even when the lane was squashed
            prev_issued <= issue_i;
        end
    end

    // output registers, load zero when squashed, hold while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_o        <= '0;
            inst_o        <= '0;
            reg_we_o      <= 1'b0;
            reg_waddr_o   <= '0;
            reg1_raddr_o  <= '0;
            reg2_raddr_o  <= '0;
            csr_we_o      <= 1'b0;
            csr_waddr_o   <= '0;
            csr_raddr_o   <= '0;
            imm_o         <= '0;
            dec_info_o    <= '0;
            pred_branch_o <= 1'b0;
            illegal_o     <= 1'b0;
            commit_id_o   <= '0;
            valid_o       <= 1'b0;
        end else if (!stall_i) begin
            if (squash) begin
                addr_o        <= '0;
                inst_o        <= '0;
                reg_we_o      <= 1'b0;
                reg_waddr_o   <= '0;
                reg1_raddr_o  <= '0;
                reg2_raddr_o  <= '0;
                csr_we_o      <= 1'b0;
                csr_waddr_o   <= '0;
                csr_raddr_o   <= '0;
                imm_o         <= '0;
                dec_info_o    <= '0;
                pred_branch_o <= 1'b0;
                illegal_o     <= 1'b0;
                commit_id_o   <= '0;
                valid_o       <= 1'b0;
            end else begin
                addr_o        <= addr_i;
                inst_o        <= inst_i;
                reg_we_o      <= reg_we_i;
                reg_waddr_o   <= reg_waddr_i;
                reg1_raddr_o  <= reg1_raddr_i;
                reg2_raddr_o  <= reg2_raddr_i;
                csr_we_o      <= csr_we_i;
                csr_waddr_o   <= csr_waddr_i;
                csr_raddr_o   <= csr_raddr_i;
                imm_o         <= imm_i;
                dec_info_o    <= dec_info_i;
                pred_branch_o <= pred_branch_i;
                illegal_o     <= illegal_i;
                commit_id_o   <= commit_id_i;
                // squash already covers a low issue bit
                valid_o       <= issue_i;
            end
        end
    end

    // dispatch stall freezes what execute sees
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_i |=> ($stable(valid_o) && $stable(addr_o))
    ) else $error("issue_lane: outputs moved during stall");

    // a flush that is not stalled kills the next slot
    a_flush_kill: assert property (
        @(posedge clk) disable iff (!rst_n)
        (flush_i && !stall_i) |=> !valid_o
    ) else $error("issue_lane: valid after flush");

    // a repeat of an issued instruction never reaches execute
    a_no_double_issue: assert property (
        @(posedge clk) disable iff (!rst_n)
        (already_issued_o && !stall_i) |=> !valid_o
    ) else $error("issue_lane: instruction issued twice");

endmodule

/* rtl/issue_pkg.sv */
/*
 * field types shared by the issue lanes, the stage and the testbench
 */

`include "issue_defs.svh"

package issue_pkg;

    // program counter of the instruction
    typedef logic [`INST_ADDR_WIDTH-1:0] inst_addr_t;

    // raw instruction as fetched
    typedef logic [`INST_DATA_WIDTH-1:0] inst_word_t;

    // source and destination register index
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // csr read and write address
    typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;

    // sign-extended immediate from decode
    typedef logic [`IMM_WIDTH-1:0] imm_t;

    // decode info bus
    // layout is owned by decode and execute, this stage only carries it
    typedef logic [`DECINFO_WIDTH-1:0] dec_info_t;

    // tag into the commit fifo
    typedef logic [`COMMIT_ID_WIDTH-1:0] commit_id_t;

endpackage

/* include/issue_defs.svh */
/*
 * issue stage widths and lane count
 */

`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// one lane per issue slot
`define ISSUE_LANES      2

// instruction address and raw word
`define INST_ADDR_WIDTH  32
`define INST_DATA_WIDTH  32

// integer register index
`define REG_ADDR_WIDTH   5

// csr addresses travel as a full word
`define CSR_ADDR_WIDTH   32

// decoded immediate
`define IMM_WIDTH        32

// decode info bus from the decoder
`define DECINFO_WIDTH    48

// commit fifo tag
`define COMMIT_ID_WIDTH  4

`endif
